// ==== common/mcb_pkg.sv ====
`default_nettype none

package mcb_pkg;

  localparam int MCB_DATA_W = 32; // Bus data and mesh words
  localparam int MCB_ADR_W  = 12;

  typedef logic [MCB_DATA_W-1:0] mcb_word_t;

  // Register index, from wb_adr_i[5:2]
  typedef enum logic [3:0] {
    REG_HOST_REQ_DATA  = 4'd0, // Write pushes
    REG_HOST_REQ_SPACE = 4'd1,
    REG_MC_RSP_DATA    = 4'd2, // Read pops
    REG_MC_RSP_COUNT   = 4'd3,
    REG_MC_REQ_DATA    = 4'd4, // Read pops
    REG_MC_REQ_COUNT   = 4'd5,
    REG_HOST_RSP_DATA  = 4'd6, // Write pushes
    REG_HOST_RSP_SPACE = 4'd7,
    REG_CREDITS_USED   = 4'd8
  } mcb_reg_e;

  // Indexes 9 to 15 are unmapped

  localparam int MCB_FIFO_DEPTH_DEF  = 4;
  localparam int MCB_MAX_CREDITS_DEF = 8;

endpackage

`default_nettype wire

// ==== mcb_fifo/mcb_word_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module mcb_word_fifo #(
  parameter int DEPTH = mcb_pkg::MCB_FIFO_DEPTH_DEF
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  mcb_pkg::mcb_word_t         data_i,
  input  logic                       pop_i,
  output mcb_pkg::mcb_word_t         data_o,
  output logic                       full_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);
  import mcb_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  mcb_word_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  // Wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_o == '0);
  assign full_o  = (count_o == DEPTH);
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop); // Full plus pop frees a slot
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(push_i && full_o && !pop_i)
  ) else $error("push into full FIFO");

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(pop_i && empty_o)
  ) else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// ==== mcb_fifo/mcb_queue_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

module mcb_queue_exec #(
  parameter int FIFO_DEPTH  = mcb_pkg::MCB_FIFO_DEPTH_DEF,
  parameter int MAX_CREDITS = mcb_pkg::MCB_MAX_CREDITS_DEF
) (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic               op_v_i,
  input  logic               op_we_i,
  input  mcb_pkg::mcb_reg_e  op_reg_i,
  input  mcb_pkg::mcb_word_t op_data_i,

  // Outbound streams
  output mcb_pkg::mcb_word_t host_req_o,
  output logic               host_req_v_o,
  input  logic               host_req_ready_i,
  output mcb_pkg::mcb_word_t host_rsp_o,
  output logic               host_rsp_v_o,
  input  logic               host_rsp_ready_i,

  // Inbound streams
  input  mcb_pkg::mcb_word_t mc_req_i,
  input  logic               mc_req_v_i,
  output logic               mc_req_ready_o,
  input  mcb_pkg::mcb_word_t mc_rsp_i,
  input  logic               mc_rsp_v_i,
  output logic               mc_rsp_ready_o,

  output mcb_pkg::mcb_word_t mc_rsp_head_o,
  output mcb_pkg::mcb_word_t mc_req_head_o,
  output mcb_pkg::mcb_word_t host_req_space_o,
  output mcb_pkg::mcb_word_t host_rsp_space_o,
  output mcb_pkg::mcb_word_t mc_rsp_count_o,
  output mcb_pkg::mcb_word_t mc_req_count_o,
  output mcb_pkg::mcb_word_t credits_used_o
);
  import mcb_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int CRD_W = $clog2(MAX_CREDITS + 1);

  logic bus_wr;
  logic bus_rd;

  logic hreq_push, hreq_pop, hreq_full, hreq_empty;
  logic hrsp_push, hrsp_pop, hrsp_full, hrsp_empty;
  logic mreq_push, mreq_pop, mreq_full, mreq_empty;
  logic mrsp_push, mrsp_pop, mrsp_full, mrsp_empty;
  logic [CNT_W-1:0] hreq_cnt, hrsp_cnt, mreq_cnt, mrsp_cnt;
  mcb_word_t mreq_data, mrsp_data;

  logic [CRD_W-1:0] credits_q;
  logic             crd_inc;
  logic             crd_dec;

  assign bus_wr = op_v_i && op_we_i;
  assign bus_rd = op_v_i && !op_we_i;

  // Writes to a full queue are dropped
  assign hreq_push = bus_wr && (op_reg_i == REG_HOST_REQ_DATA) && !hreq_full;
  assign hrsp_push = bus_wr && (op_reg_i == REG_HOST_RSP_DATA) && !hrsp_full;
  assign mreq_pop  = bus_rd && (op_reg_i == REG_MC_REQ_DATA) && !mreq_empty;
  assign mrsp_pop  = bus_rd && (op_reg_i == REG_MC_RSP_DATA) && !mrsp_empty;

  assign host_req_v_o = !hreq_empty && (credits_q < MAX_CREDITS); // Credit gate
  assign hreq_pop     = host_req_v_o && host_req_ready_i;
  assign host_rsp_v_o = !hrsp_empty;
  assign hrsp_pop     = host_rsp_v_o && host_rsp_ready_i;

  assign mc_req_ready_o = !mreq_full;
  assign mreq_push      = mc_req_v_i && mc_req_ready_o;
  assign mc_rsp_ready_o = !mrsp_full;
  assign mrsp_push      = mc_rsp_v_i && mc_rsp_ready_o;

  mcb_word_fifo #(.DEPTH(FIFO_DEPTH)) u_host_req_fifo (
    .clk_i, .rst_n_i, .push_i(hreq_push), .data_i(op_data_i), .pop_i(hreq_pop),
    .data_o(host_req_o), .full_o(hreq_full), .empty_o(hreq_empty), .count_o(hreq_cnt)
  );

  mcb_word_fifo #(.DEPTH(FIFO_DEPTH)) u_host_rsp_fifo (
    .clk_i, .rst_n_i, .push_i(hrsp_push), .data_i(op_data_i), .pop_i(hrsp_pop),
    .data_o(host_rsp_o), .full_o(hrsp_full), .empty_o(hrsp_empty), .count_o(hrsp_cnt)
  );

  mcb_word_fifo #(.DEPTH(FIFO_DEPTH)) u_mc_req_fifo (
    .clk_i, .rst_n_i, .push_i(mreq_push), .data_i(mc_req_i), .pop_i(mreq_pop),
    .data_o(mreq_data), .full_o(mreq_full), .empty_o(mreq_empty), .count_o(mreq_cnt)
  );

  mcb_word_fifo #(.DEPTH(FIFO_DEPTH)) u_mc_rsp_fifo (
    .clk_i, .rst_n_i, .push_i(mrsp_push), .data_i(mc_rsp_i), .pop_i(mrsp_pop),
    .data_o(mrsp_data), .full_o(mrsp_full), .empty_o(mrsp_empty), .count_o(mrsp_cnt)
  );

  // Outstanding request credits
  assign crd_inc = hreq_pop;
  assign crd_dec = mrsp_push && (credits_q != '0); // Stray response returns nothing

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credits_q <= '0;
    end else begin
      case ({crd_inc, crd_dec})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  assign mc_rsp_head_o    = mrsp_empty ? '0 : mrsp_data;
  assign mc_req_head_o    = mreq_empty ? '0 : mreq_data;
  assign host_req_space_o = mcb_word_t'(FIFO_DEPTH) - mcb_word_t'(hreq_cnt);
  assign host_rsp_space_o = mcb_word_t'(FIFO_DEPTH) - mcb_word_t'(hrsp_cnt);
  assign mc_rsp_count_o   = mcb_word_t'(mrsp_cnt);
  assign mc_req_count_o   = mcb_word_t'(mreq_cnt);
  assign credits_used_o   = mcb_word_t'(credits_q);

  a_credit_limit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    credits_q <= MAX_CREDITS
  ) else $error("credits above MAX_CREDITS");

endmodule

`default_nettype wire

// ==== hw/mcb_bus_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mcb_bus_decode (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [mcb_pkg::MCB_ADR_W-1:0] wb_adr_i,
  input  mcb_pkg::mcb_word_t            wb_dat_i,

  output logic                          op_v_o,
  output logic                          op_we_o,
  output mcb_pkg::mcb_reg_e             op_reg_o,
  output mcb_pkg::mcb_word_t            op_data_o
);
  import mcb_pkg::*;

  logic bus_req;
  logic taken_q; // Strobe already turned into an op
  logic issue;

  assign bus_req = wb_cyc_i && wb_stb_i;
  assign issue   = bus_req && !taken_q;

  // Control flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      op_v_o  <= 1'b0;
      taken_q <= 1'b0;
    end else begin
      op_v_o <= issue;
      if (issue) begin
        taken_q <= 1'b1;
      end else if (!bus_req) begin
        taken_q <= 1'b0; // Strobe fell, ready for next cycle
      end
    end
  end

  // Operation payload
  always_ff @(posedge clk_i) begin
    if (issue) begin
      op_we_o   <= wb_we_i;
      op_reg_o  <= mcb_reg_e'(wb_adr_i[5:2]); // Word index
      op_data_o <= wb_dat_i;
    end
  end

  // One op per strobe, never back to back
  a_op_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    op_v_o |=> !op_v_o
  ) else $error("op_v_o high for two cycles");

endmodule

`default_nettype wire

// ==== hw/mcb_read_result.sv ====
`timescale 1ns/1ns
`default_nettype none

module mcb_read_result (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic               op_v_i,
  input  logic               op_we_i,
  input  mcb_pkg::mcb_reg_e  op_reg_i,

  input  mcb_pkg::mcb_word_t mc_rsp_head_i,
  input  mcb_pkg::mcb_word_t mc_req_head_i,
  input  mcb_pkg::mcb_word_t host_req_space_i,
  input  mcb_pkg::mcb_word_t host_rsp_space_i,
  input  mcb_pkg::mcb_word_t mc_rsp_count_i,
  input  mcb_pkg::mcb_word_t mc_req_count_i,
  input  mcb_pkg::mcb_word_t credits_used_i,

  output mcb_pkg::mcb_word_t wb_dat_o,
  output logic               wb_ack_o
);
  import mcb_pkg::*;

  mcb_word_t rd_word;

  // Heads are sampled before the pop lands
  always_comb begin
    rd_word = '0;
    if (!op_we_i) begin
      case (op_reg_i)
        REG_HOST_REQ_SPACE: rd_word = host_req_space_i;
        REG_MC_RSP_DATA:    rd_word = mc_rsp_head_i;
        REG_MC_RSP_COUNT:   rd_word = mc_rsp_count_i;
        REG_MC_REQ_DATA:    rd_word = mc_req_head_i;
        REG_MC_REQ_COUNT:   rd_word = mc_req_count_i;
        REG_HOST_RSP_SPACE: rd_word = host_rsp_space_i;
        REG_CREDITS_USED:   rd_word = credits_used_i;
        default:            rd_word = '0; // Write-only and unmapped
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= op_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_v_i) wb_dat_o <= rd_word;
  end

  // Ack is a one-cycle pulse
  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |=> !wb_ack_o
  ) else $error("ack not a single cycle pulse");

endmodule

`default_nettype wire

// ==== hw/mcb_bridge_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mcb_bridge_top #(
  parameter int FIFO_DEPTH  = mcb_pkg::MCB_FIFO_DEPTH_DEF,
  parameter int MAX_CREDITS = mcb_pkg::MCB_MAX_CREDITS_DEF
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  // Wishbone classic slave
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [mcb_pkg::MCB_ADR_W-1:0] wb_adr_i,
  input  mcb_pkg::mcb_word_t            wb_dat_i,
  output mcb_pkg::mcb_word_t            wb_dat_o,
  output logic                          wb_ack_o,

  // Mesh streams
  output mcb_pkg::mcb_word_t            host_req_o,
  output logic                          host_req_v_o,
  input  logic                          host_req_ready_i,
  output mcb_pkg::mcb_word_t            host_rsp_o,
  output logic                          host_rsp_v_o,
  input  logic                          host_rsp_ready_i,
  input  mcb_pkg::mcb_word_t            mc_req_i,
  input  logic                          mc_req_v_i,
  output logic                          mc_req_ready_o,
  input  mcb_pkg::mcb_word_t            mc_rsp_i,
  input  logic                          mc_rsp_v_i,
  output logic                          mc_rsp_ready_o
);
  import mcb_pkg::*;

  logic      op_v;
  logic      op_we;
  mcb_reg_e  op_reg;
  mcb_word_t op_data;

  mcb_word_t mc_rsp_head, mc_req_head;
  mcb_word_t host_req_space, host_rsp_space;
  mcb_word_t mc_rsp_count, mc_req_count;
  mcb_word_t credits_used;

  mcb_bus_decode u_mcb_bus_decode (
    .clk_i, .rst_n_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .op_v_o(op_v), .op_we_o(op_we), .op_reg_o(op_reg), .op_data_o(op_data)
  );

  mcb_queue_exec #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .MAX_CREDITS(MAX_CREDITS)
  ) u_mcb_queue_exec (
    .clk_i, .rst_n_i,
    .op_v_i(op_v), .op_we_i(op_we), .op_reg_i(op_reg), .op_data_i(op_data),
    .host_req_o, .host_req_v_o, .host_req_ready_i,
    .host_rsp_o, .host_rsp_v_o, .host_rsp_ready_i,
    .mc_req_i, .mc_req_v_i, .mc_req_ready_o,
    .mc_rsp_i, .mc_rsp_v_i, .mc_rsp_ready_o,
    .mc_rsp_head_o(mc_rsp_head), .mc_req_head_o(mc_req_head),
    .host_req_space_o(host_req_space), .host_rsp_space_o(host_rsp_space),
    .mc_rsp_count_o(mc_rsp_count), .mc_req_count_o(mc_req_count),
    .credits_used_o(credits_used)
  );

  mcb_read_result u_mcb_read_result (
    .clk_i, .rst_n_i,
    .op_v_i(op_v), .op_we_i(op_we), .op_reg_i(op_reg),
    .mc_rsp_head_i(mc_rsp_head), .mc_req_head_i(mc_req_head),
    .host_req_space_i(host_req_space), .host_rsp_space_i(host_rsp_space),
    .mc_rsp_count_i(mc_rsp_count), .mc_req_count_i(mc_req_count),
    .credits_used_i(credits_used),
    .wb_dat_o, .wb_ack_o
  );

endmodule

`default_nettype wire

// ==== testbench/tb_mcb_tasks.svh ====
`ifndef TB_MCB_TASKS_SVH
`define TB_MCB_TASKS_SVH

task automatic stop_on_error();
  $display("FAIL: see errors above");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_word(input string what, input mcb_word_t exp, input mcb_word_t act);
  if (exp !== act) begin
    $display("FAILED %s, %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    stop_on_error();
  end
endtask

task automatic check_count(input string what, input mcb_word_t exp, input mcb_word_t act);
  if (exp !== act) begin
    $display("FAILED %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
    stop_on_error();
  end
endtask

// Entered and left 1 ns after a rising edge
task automatic bus_access(input logic we, input logic [3:0] idx, input mcb_word_t wdata,
                          output mcb_word_t rdata);
  int edges;
  check_count("ack low before access", 0, wb_ack);
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we  = we;
  wb_adr = '0;
  wb_adr[5:2] = idx;
  wb_dat_w = wdata;
  edges = 0;
  while (!wb_ack) begin
    if (edges == TIMEOUT_CYCLES) begin
      $display("No acknowledge within %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
      stop_on_error();
    end
    @(posedge clk);
    #1;
    edges++;
  end
  rdata = wb_dat_r;
  check_count("ack latency in edges", 2, edges);
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
  @(posedge clk);
  #1;
  check_count("ack after one cycle", 0, wb_ack); // Single pulse
endtask

task automatic wb_write(input logic [3:0] idx, input mcb_word_t wdata);
  mcb_word_t unused;
  bus_access(1'b1, idx, wdata, unused);
endtask

task automatic wb_read(input logic [3:0] idx, output mcb_word_t rdata);
  bus_access(1'b0, idx, '0, rdata);
endtask

task automatic mesh_send(input logic to_rsp, input mcb_word_t word);
  int waited;
  mc_rsp   = word;
  mc_req   = word;
  mc_rsp_v = to_rsp;
  mc_req_v = !to_rsp;
  waited = 0;
  while (!(to_rsp ? mc_rsp_ready : mc_req_ready)) begin
    if (waited == TIMEOUT_CYCLES) begin
      $display("Inbound ready stayed low for %0d cycles in test %s", waited, test_name);
      stop_on_error();
    end
    @(posedge clk);
    #1;
    waited++;
  end
  @(posedge clk); // Transfer edge
  #1;
  mc_rsp_v = 1'b0;
  mc_req_v = 1'b0;
endtask

task automatic mesh_expect(input logic from_rsp, input mcb_word_t exp, input string what);
  int waited;
  host_rsp_ready = from_rsp;
  host_req_ready = !from_rsp;
  waited = 0;
  while (!(from_rsp ? host_rsp_v : host_req_v)) begin
    if (waited == TIMEOUT_CYCLES) begin
      $display("No outbound word within %0d cycles in test %s", waited, test_name);
      stop_on_error();
    end
    @(posedge clk);
    #1;
    waited++;
  end
  check_word(what, exp, from_rsp ? host_rsp : host_req);
  @(posedge clk);
  #1;
  host_rsp_ready = 1'b0;
  host_req_ready = 1'b0;
endtask

// Ready held high, valid must stay low
task automatic mesh_quiet(input logic from_rsp, input int cycles);
  host_rsp_ready = from_rsp;
  host_req_ready = !from_rsp;
  repeat (cycles) begin
    check_count("outbound valid while blocked", 0, from_rsp ? host_rsp_v : host_req_v);
    @(posedge clk);
    #1;
  end
  host_rsp_ready = 1'b0;
  host_req_ready = 1'b0;
endtask

`endif

// ==== testbench/tb_mcb_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mcb_bridge;
  import mcb_pkg::*;

  localparam int DEPTH          = MCB_FIFO_DEPTH_DEF;
  localparam int CREDITS        = MCB_MAX_CREDITS_DEF;
  localparam int TIMEOUT_CYCLES = 100;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc, wb_stb, wb_we, wb_ack;
  logic [MCB_ADR_W-1:0] wb_adr;
  mcb_word_t            wb_dat_w, wb_dat_r;
  mcb_word_t            host_req, host_rsp, mc_req, mc_rsp;
  logic                 host_req_v, host_req_ready, host_rsp_v, host_rsp_ready;
  logic                 mc_req_v, mc_req_ready, mc_rsp_v, mc_rsp_ready;

  integer    seed = 32'hf4cf88e0;
  string     test_name;
  int        credits_model; // Expected outstanding requests
  mcb_word_t host_req_pending[$];

  `include "tb_mcb_tasks.svh"

  mcb_bridge_top #(
    .FIFO_DEPTH (DEPTH),
    .MAX_CREDITS(CREDITS)
  ) u_mcb_bridge_top (
    .clk_i(clk), .rst_n_i(rst_n),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
    .host_req_o(host_req), .host_req_v_o(host_req_v), .host_req_ready_i(host_req_ready),
    .host_rsp_o(host_rsp), .host_rsp_v_o(host_rsp_v), .host_rsp_ready_i(host_rsp_ready),
    .mc_req_i(mc_req), .mc_req_v_i(mc_req_v), .mc_req_ready_o(mc_req_ready),
    .mc_rsp_i(mc_rsp), .mc_rsp_v_i(mc_rsp_v), .mc_rsp_ready_o(mc_rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Pass on queued requests while credits allow
  task automatic release_host_requests();
    while (host_req_pending.size() > 0 && credits_model < CREDITS) begin
      mesh_expect(1'b0, host_req_pending.pop_front(), "request word");
      credits_model++;
    end
  endtask

  task automatic test_reset_values();
    mcb_word_t rd;
    test_name = "reset values";
    wb_read(REG_HOST_REQ_SPACE, rd);
    check_count("host request space", DEPTH, rd);
    wb_read(REG_HOST_RSP_SPACE, rd);
    check_count("host response space", DEPTH, rd);
    wb_read(REG_MC_RSP_COUNT, rd);
    check_count("mesh response count", 0, rd);
    wb_read(REG_MC_REQ_COUNT, rd);
    check_count("mesh request count", 0, rd);
    wb_read(REG_CREDITS_USED, rd);
    check_count("credits used", 0, rd);
    wb_read(REG_MC_RSP_DATA, rd);
    check_word("empty response data", 0, rd);
    wb_read(REG_MC_REQ_DATA, rd);
    check_word("empty request data", 0, rd);
    wb_read(4'd12, rd);
    check_word("unmapped index", 0, rd);
  endtask

  task automatic test_host_req_path();
    mcb_word_t w;
    mcb_word_t rd;
    test_name = "host request path";
    for (int i = 0; i < DEPTH + 1; i++) begin
      w = $random(seed);
      wb_write(REG_HOST_REQ_DATA, w);
      if (i < DEPTH) host_req_pending.push_back(w); // Last one hits a full FIFO
    end
    wb_read(REG_HOST_REQ_SPACE, rd);
    check_count("space when full", 0, rd);
    release_host_requests();
    mesh_quiet(1'b0, 8);
    wb_read(REG_CREDITS_USED, rd);
    check_count("credits after drain", credits_model, rd);
    wb_read(REG_HOST_REQ_SPACE, rd);
    check_count("space after drain", DEPTH, rd);
  endtask

  task automatic test_credit_limit();
    mcb_word_t rsp_q[$];
    mcb_word_t w;
    mcb_word_t rd;
    int        written;
    int        batch;
    test_name = "credit limit";
    while (credits_model > 0) begin
      w = $random(seed);
      mesh_send(1'b1, w);
      rsp_q.push_back(w);
      credits_model--;
    end
    check_count("response ready when full", rsp_q.size() < DEPTH, mc_rsp_ready);
    while (rsp_q.size() > 0) begin
      wb_read(REG_MC_RSP_DATA, rd);
      check_word("returned response", rsp_q.pop_front(), rd);
    end
    written = 0;
    while (written < CREDITS + 2) begin
      batch = DEPTH - host_req_pending.size();
      if (batch > CREDITS + 2 - written) batch = CREDITS + 2 - written;
      if (batch == 0) begin
        $display("Host request FIFO stayed full in test %s", test_name);
        stop_on_error();
      end
      repeat (batch) begin
        w = $random(seed);
        wb_write(REG_HOST_REQ_DATA, w);
        host_req_pending.push_back(w);
      end
      written += batch;
      release_host_requests();
    end
    wb_read(REG_HOST_REQ_SPACE, rd);
    check_count("space with requests held", DEPTH - 2, rd);
    mesh_quiet(1'b0, 8);
    wb_read(REG_CREDITS_USED, rd);
    check_count("credits at limit", CREDITS, rd);
    repeat (2) begin
      w = $random(seed);
      mesh_send(1'b1, w);
      rsp_q.push_back(w);
      credits_model--;
    end
    release_host_requests();
    wb_read(REG_HOST_REQ_SPACE, rd);
    check_count("space after responses", DEPTH, rd);
    wb_read(REG_CREDITS_USED, rd);
    check_count("credits after responses", credits_model, rd);
    while (rsp_q.size() > 0) begin
      wb_read(REG_MC_RSP_DATA, rd);
      check_word("response data", rsp_q.pop_front(), rd);
    end
    wb_read(REG_MC_RSP_DATA, rd);
    check_word("response data when empty", 0, rd);
  endtask

  task automatic test_mc_req_path();
    mcb_word_t req_q[$];
    mcb_word_t w;
    mcb_word_t rd;
    int        sent;
    test_name = "inbound mesh requests";
    sent = 0;
    while (mc_req_ready && sent <= DEPTH) begin
      w = $random(seed);
      mesh_send(1'b0, w);
      req_q.push_back(w);
      sent++;
    end
    check_count("words before ready low", DEPTH, sent);
    check_count("ready when full", 0, mc_req_ready);
    wb_read(REG_MC_REQ_COUNT, rd);
    check_count("request count", DEPTH, rd);
    while (req_q.size() > 0) begin
      wb_read(REG_MC_REQ_DATA, rd);
      check_word("request data", req_q.pop_front(), rd);
    end
    wb_read(REG_MC_REQ_DATA, rd);
    check_word("request data when empty", 0, rd);
    check_count("ready after pops", 1, mc_req_ready);
  endtask

  task automatic test_host_rsp_path();
    mcb_word_t rsp_q[$];
    mcb_word_t w;
    mcb_word_t rd;
    test_name = "host response path";
    repeat (DEPTH) begin
      w = $random(seed);
      wb_write(REG_HOST_RSP_DATA, w);
      rsp_q.push_back(w);
    end
    wb_read(REG_HOST_RSP_SPACE, rd);
    check_count("space when full", 0, rd);
    while (rsp_q.size() > 0) mesh_expect(1'b1, rsp_q.pop_front(), "response word");
    wb_read(REG_HOST_RSP_SPACE, rd);
    check_count("space after drain", DEPTH, rd);
  endtask

  // Latency and pulse width are checked on every access
  task automatic test_ack_timing();
    mcb_word_t rd;
    test_name = "acknowledge timing";
    repeat (5) begin
      check_count("ack while idle", 0, wb_ack);
      @(posedge clk);
      #1;
    end
    wb_write(4'd15, 32'hdead_beef);
    wb_write(REG_CREDITS_USED, 32'h0000_0003); // Read-only, ignored
    wb_read(REG_CREDITS_USED, rd);
    check_count("credits unchanged", credits_model, rd);
  endtask

  initial begin
    rst_n          = 1'b0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    host_req_ready = 1'b0;
    host_rsp_ready = 1'b0;
    mc_req         = '0;
    mc_req_v       = 1'b0;
    mc_rsp         = '0;
    mc_rsp_v       = 1'b0;
    credits_model  = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_values();
    test_host_req_path();
    test_credit_limit();
    test_mc_req_path();
    test_host_rsp_path();
    test_ack_timing();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+testbench
common/mcb_pkg.sv
mcb_fifo/mcb_word_fifo.sv
mcb_fifo/mcb_queue_exec.sv
hw/mcb_bus_decode.sv
hw/mcb_read_result.sv
hw/mcb_bridge_top.sv
testbench/tb_mcb_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mcb_bridge \
  -f project.f -Mdir obj_dir -o tb_mcb_bridge > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mcb_bridge > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Verdict comes from the log
if grep -q "^PASS: all tests$" sim.log; then
  echo "Result: passed"
  exit 0
fi
echo "Result: failed"
exit 1
